// ==== obj_engine.f ====
rtl/obj_pkg.sv
rtl/obj_frame_table.sv
rtl/obj_tile_match.sv
rtl/obj_scan.sv
rtl/obj_line_drawer.sv
rtl/obj_line_buffer.sv
rtl/obj_engine.sv
tests/obj_engine_checker.sv
tests/obj_engine_tb.sv

// ==== Bender.yml ====
package:
  name: obj_engine

sources:
  - rtl/obj_pkg.sv
  - rtl/obj_frame_table.sv
  - rtl/obj_tile_match.sv
  - rtl/obj_scan.sv
  - rtl/obj_line_drawer.sv
  - rtl/obj_line_buffer.sv
  - rtl/obj_engine.sv
  - target: test
    files:
      - tests/obj_engine_checker.sv
      - tests/obj_engine_tb.sv

// ==== tests/obj_engine_tb.sv ====
/*
 * object line engine testbench
 * drives line timing, loads the object table and models graphics memory
 */
`timescale 1ns/10ps

module obj_engine_tb;

    localparam int TEST_LINES  = 24;
    localparam int CYCLE_LIMIT = 512 * TEST_LINES + 1024;
    localparam int LW          = 512 * obj_pkg::PIX_W;

    logic        clk = 1'b0;
    logic        rst;
    logic        flip;
    logic [8:0]  vrender1;
    logic [8:0]  hdump;
    logic [9:0]  off_x;
    logic [9:0]  off_y;
    logic        cpu_we;
    logic [obj_pkg::HOST_AW-1:0] cpu_addr;
    logic [15:0] cpu_data;
    logic        rom_cs;
    logic [obj_pkg::ROM_AW-1:0] rom_addr;
    logic        rom_ok;
    logic [obj_pkg::ROM_DW-1:0] rom_data;
    logic        line;
    logic [obj_pkg::PIX_W-1:0] pix;

    logic [LW-1:0] exp_in;
    logic        exp_load;
    int          errors;
    int          checks;
    int          cycles;
    int          scans;
    logic [31:0] rng;
    logic [1:0]  delay;     // remaining memory wait
    logic        busy;
    logic [15:0] tbl [1024][4];   // copy of the object table

    always #4 clk = ~clk;

    obj_engine obj_engine_inst (
        .clk      (clk),
        .rst      (rst),
        .flip     (flip),
        .vrender1 (vrender1),
        .hdump    (hdump),
        .off_x    (off_x),
        .off_y    (off_y),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .line     (line),
        .pix      (pix)
    );

    obj_engine_checker u_checker (
        .clk      (clk),
        .rst      (rst),
        .hdump    (hdump),
        .line     (line),
        .pix      (pix),
        .exp_load (exp_load),
        .exp_in   (exp_in),
        .errors   (errors),
        .checks   (checks)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // graphics memory contents, a hash of the address
    function automatic logic [63:0] row_hash(input logic [21:0] a);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = xorshift({10'h2a5, a});
        hi = xorshift(lo ^ 32'h5bd1_e995);
        return {hi, lo};
    endfunction

    // expected 512-pixel line for one scan, later entries drawn over earlier ones
    function automatic logic [LW-1:0] expected_line(input logic [8:0] vr);
        logic [LW-1:0] res;
        logic [8:0]  vf;
        logic [9:0]  objx;
        logic [9:0]  objy;
        logic [9:0]  dy;
        logic [9:0]  pos;
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] code;
        logic [15:0] attr;
        logic [15:0] cmn;
        logic [3:0]  rowi;
        logic [3:0]  vsub;
        logic [3:0]  colour;
        logic [8:0]  dest;
        logic [63:0] data;
        res = '1;
        vf = flip ? vr ^ 9'h0ff : vr;
        for (int e = 0; e < 1024; e++) begin
            x    = tbl[e][0];
            y    = tbl[e][1];
            code = tbl[e][2];
            attr = tbl[e][3];
            if (y[15] || attr[15:8] == 8'hff) begin
                break;
            end
            objx = x[9:0] + 10'h40 - (attr[7] ? 10'd0 : off_x);
            objy = y[9:0] + 10'h10 - (attr[7] ? 10'd0 : off_y);
            dy   = {1'b0, vf} - objy;
            // line inside the m+1 rows of 16 lines
            if (int'(dy) < 16 * (int'(attr[15:12]) + 1)) begin
                rowi = attr[6] ? attr[15:12] - 4'(dy / 16) : 4'(dy / 16);
                vsub = attr[6] ? 4'(15 - dy % 16) : 4'(dy % 16);
                for (int c = 0; c <= attr[11:8]; c++) begin
                    pos = attr[5] ? objx - 10'(16 * c) : objx + 10'(16 * c);
                    if (!pos[9]) begin
                        cmn  = {code[15:8], code[7:4] + rowi, code[3:0] + 4'(c)};
                        data = row_hash({y[14:13], cmn, vsub});
                        for (int p = 0; p < 16; p++) begin
                            colour = data[4*p +: 4];
                            dest   = pos[8:0] - 9'd1 + 9'(attr[5] ? 15 - p : p);
                            if (colour != 4'hf) begin
                                res[dest*obj_pkg::PIX_W +: obj_pkg::PIX_W] =
                                    {x[15:13], attr[4:0], colour};
                            end
                        end
                    end
                end
            end
        end
        return res;
    endfunction

    // line timing, expected line handed over as each scan starts
    always @(negedge clk) begin
        if (rst) begin
            hdump    <= '0;
            exp_load <= 1'b0;
        end else begin
            hdump    <= hdump + 9'd1;
            exp_load <= 1'b0;
            if (hdump == 9'h1ff) begin
                vrender1 <= vrender1 + 9'd1;
            end
            if (hdump + 9'd1 == obj_pkg::SCAN_START) begin
                scans    <= scans + 1;
                exp_in   <= expected_line(vrender1);
                exp_load <= scans > 0;  // first scan draws into a bank never erased
            end
        end
    end

    // graphics memory with a random wait
    always @(negedge clk) begin
        if (rst || rom_ok) begin
            rom_ok <= 1'b0;
            busy   <= 1'b0;
        end else if (busy) begin
            if (delay == 2'd0) begin
                rom_ok   <= 1'b1;
                rom_data <= row_hash(rom_addr);
            end else begin
                delay <= delay - 2'd1;
            end
        end else if (rom_cs) begin
            rng = xorshift(rng);
            busy  <= 1'b1;
            delay <= rng[1:0];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic write_word(input int a, input logic [15:0] d);
        @(negedge clk);
        cpu_we   = 1'b1;
        cpu_addr = 12'(a);
        cpu_data = d;
        tbl[a / 4][a % 4] = d;
    endtask

    // sx, sy are screen positions, turned back into raw table values
    task automatic put_obj(input int idx, input logic [9:0] sx, input logic [9:0] sy,
                           input logic [2:0] prio, input logic [1:0] bank,
                           input logic [15:0] code, input logic [15:0] attr);
        logic [9:0] xx;
        logic [9:0] yy;
        xx = sx - 10'h40 + (attr[7] ? 10'd0 : off_x);
        yy = sy - 10'h10 + (attr[7] ? 10'd0 : off_y);
        write_word(idx * 4, {prio, 3'b000, xx});
        write_word(idx * 4 + 1, {1'b0, bank, 3'b000, yy});
        write_word(idx * 4 + 2, code);
        write_word(idx * 4 + 3, attr);
    endtask

    task automatic put_end(input int idx);
        write_word(idx * 4, 16'h0000);
        write_word(idx * 4 + 1, 16'h8000);
        write_word(idx * 4 + 2, 16'h0000);
        write_word(idx * 4 + 3, 16'h0000);
        @(negedge clk);
        cpu_we = 1'b0;
    endtask

    // returns at hdump 0x160, the table write window before the next scan
    task automatic run_lines(input int n);
        repeat (n) begin
            @(negedge clk);
            while (hdump != 9'h160) begin
                @(negedge clk);
            end
        end
    endtask

    function automatic logic [9:0] cur_line();
        return {1'b0, flip ? vrender1 ^ 9'h0ff : vrender1};
    endfunction

    initial begin
        rst      = 1'b1;
        flip     = 1'b0;
        vrender1 = '0;
        hdump    = '0;
        off_x    = '0;
        off_y    = '0;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_data = '0;
        rom_ok   = 1'b0;
        rom_data = '0;
        exp_in   = '1;
        exp_load = 1'b0;
        scans    = 0;
        cycles   = 0;
        busy     = 1'b0;
        delay    = '0;
        rng      = 32'h1436_6e12;
        for (int e = 0; e < 1024; e++) begin
            for (int w = 0; w < 4; w++) begin
                tbl[e][w] = 16'h0000;
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        run_lines(1);

        // single object with offsets
        off_x = 10'h025;
        off_y = 10'h031;
        put_obj(0, 10'd100, cur_line() - 10'd2, 3'd5, 2'd1, 16'h1234, 16'h0013);
        put_end(1);
        run_lines(3);

        // 3 by 2 objects, one with hflip and one with vflip
        put_obj(0, 10'd200, cur_line() - 10'd12, 3'd2, 2'd0, 16'h00fe, 16'h122a);
        put_obj(1, 10'd300, cur_line() - 10'd14, 3'd6, 2'd3, 16'h05f3, 16'h1247);
        put_end(2);
        run_lines(6);

        // absolute, missed rows, column past bit 9
        off_x = 10'h013;
        off_y = 10'h3f0;
        put_obj(0, 10'd40, cur_line() - 10'd3, 3'd1, 2'd2, 16'h4410, 16'h0185);
        put_obj(1, 10'd120, cur_line() + 10'd40, 3'd3, 2'd0, 16'h2000, 16'h0001);
        put_obj(2, 10'd500, cur_line() - 10'd5, 3'd4, 2'd1, 16'h3321, 16'h0211);
        put_end(3);
        run_lines(3);

        // overlap, the later entry wins
        put_obj(0, 10'd150, cur_line() - 10'd1, 3'd7, 2'd0, 16'h0a0a, 16'h0004);
        put_obj(1, 10'd158, cur_line() - 10'd6, 3'd0, 2'd2, 16'h0b0b, 16'h0019);
        put_end(2);
        run_lines(2);

        // screen flip
        flip = 1'b1;
        put_obj(0, 10'd80, cur_line() - 10'd8, 3'd2, 2'd1, 16'h7777, 16'h0306);
        put_end(1);
        run_lines(3);

        // end marker hides later entries, then an empty table
        flip = 1'b0;
        put_obj(0, 10'd50, cur_line() - 10'd4, 3'd1, 2'd0, 16'h1111, 16'h0002);
        put_end(1);
        put_obj(2, 10'd250, cur_line() - 10'd4, 3'd1, 2'd0, 16'h2222, 16'h0003);
        @(negedge clk);
        cpu_we = 1'b0;
        run_lines(2);
        put_end(0);
        run_lines(3);

        @(negedge clk);
        $display("errors %0d, pixels checked %0d", errors, checks);
        if (errors == 0 && checks > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/obj_engine_checker.sv ====
/*
 * pixel output checker
 * compares each read-out line with the expected line of its scan
 */
`timescale 1ns/10ps

module obj_engine_checker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [8:0]                    hdump,
    input  logic                          line,
    input  logic [obj_pkg::PIX_W-1:0]     pix,
    input  logic                          exp_load,
    input  logic [512*obj_pkg::PIX_W-1:0] exp_in,
    output int                            errors,
    output int                            checks
);

    logic [512*obj_pkg::PIX_W-1:0] exp_bank [2];   // expected contents per buffer bank
    logic [1:0]  valid;
    logic [8:0]  addr_q;    // address behind the current pix
    logic        sel_q;     // line value when that read happened
    logic        load_q;
    logic        live;
    logic        line_q;
    int          idle;
    int          pix_errs;
    int          line_errs;
    logic [obj_pkg::PIX_W-1:0] want;

    assign errors = pix_errs + line_errs;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_q <= '0;
            sel_q  <= 1'b0;
            load_q <= 1'b0;
            live   <= 1'b0;
        end else begin
            addr_q <= hdump;
            sel_q  <= line;
            load_q <= exp_load;
            live   <= 1'b1;
        end
    end

    // read bank is the one not selected by line
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            valid    <= 2'b00;
            pix_errs <= 0;
            checks   <= 0;
        end else if (live) begin
            want = exp_bank[!sel_q][addr_q*obj_pkg::PIX_W +: obj_pkg::PIX_W];
            if (valid[!sel_q]) begin
                checks <= checks + 1;
                if (pix !== want) begin
                    $display("Fail pix addr %h expected %h got %h", addr_q, want, pix);
                    pix_errs <= pix_errs + 1;
                end
            end
            if (load_q) begin
                exp_bank[!sel_q] <= exp_in;  // new scan writes the bank just read
                valid[!sel_q]    <= 1'b1;
            end
        end
    end

    // line must toggle once per 512-cycle line
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            line_q    <= 1'b0;
            idle      <= 0;
            line_errs <= 0;
        end else begin
            line_q <= line;
            if (line != line_q) begin
                idle <= 0;
            end else if (idle == 600) begin
                $display("line output did not toggle within %0d cycles", idle);
                line_errs <= line_errs + 1;
                idle      <= 0;
            end else begin
                idle <= idle + 1;
            end
        end
    end

endmodule

// ==== rtl/obj_engine.sv ====
/*
 * sprite line engine top
 * object table, scanner, line drawer and line buffer
 */
`timescale 1ns/10ps

module obj_engine (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flip,
    input  logic [8:0]                  vrender1,
    input  logic [8:0]                  hdump,
    input  logic [9:0]                  off_x,
    input  logic [9:0]                  off_y,
    input  logic                        cpu_we,
    input  logic [obj_pkg::HOST_AW-1:0] cpu_addr,
    input  logic [15:0]                 cpu_data,
    output logic                        rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]  rom_addr,
    input  logic                        rom_ok,
    input  logic [obj_pkg::ROM_DW-1:0]  rom_data,
    output logic                        line,
    output logic [obj_pkg::PIX_W-1:0]   pix
);

    logic [obj_pkg::TABLE_AW-1:0] table_addr;
    obj_pkg::obj_entry_t          entry;
    obj_pkg::draw_req_t           dr;
    logic                         dr_start;
    logic                         dr_idle;
    logic                         buf_we;
    logic [8:0]                   buf_addr;
    logic [obj_pkg::PIX_W-1:0]    buf_data;

    obj_frame_table u_table (
        .clk        (clk),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_data   (cpu_data),
        .table_addr (table_addr),
        .entry      (entry)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .flip       (flip),
        .vrender1   (vrender1),
        .hdump      (hdump),
        .line       (line),
        .off_x      (off_x),
        .off_y      (off_y),
        .table_addr (table_addr),
        .entry      (entry),
        .dr_start   (dr_start),
        .dr_idle    (dr_idle),
        .dr         (dr)
    );

    obj_line_drawer u_drawer (
        .clk      (clk),
        .rst      (rst),
        .dr_start (dr_start),
        .dr       (dr),
        .dr_idle  (dr_idle),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_data (buf_data)
    );

    obj_line_buffer u_buffer (
        .clk      (clk),
        .rst      (rst),
        .line     (line),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_data (buf_data),
        .hdump    (hdump),
        .pix      (pix)
    );

endmodule

// ==== rtl/obj_line_buffer.sv ====
/*
 * double line buffer
 * one bank takes drawer writes, the other is read at hdump and erased
 */
`timescale 1ns/10ps

module obj_line_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      line,
    input  logic                      buf_we,
    input  logic [8:0]                buf_addr,
    input  logic [obj_pkg::PIX_W-1:0] buf_data,
    input  logic [8:0]                hdump,
    output logic [obj_pkg::PIX_W-1:0] pix
);

    logic [obj_pkg::PIX_W-1:0] mem [2][512];

    for (genvar b = 0; b < 2; b++) begin : g_bank
        always_ff @(posedge clk) begin
            if (line == (b == 1)) begin
                if (buf_we) begin
                    mem[b][buf_addr] <= buf_data;
                end
            end else begin
                mem[b][hdump] <= obj_pkg::PIX_EMPTY;    // clear behind the read
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix <= obj_pkg::PIX_EMPTY;
        end else begin
            pix <= mem[!line][hdump];
        end
    end

    // an opaque write must never look like an erased pixel
    a_no_empty_write: assert property (@(posedge clk) disable iff (rst)
        buf_we |-> buf_data != obj_pkg::PIX_EMPTY);

endmodule

// ==== rtl/obj_line_drawer.sv ====
/*
 * line drawer
 * fetches one tile row from graphics memory and writes its opaque pixels
 */
`timescale 1ns/10ps

module obj_line_drawer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dr_start,
    input  obj_pkg::draw_req_t         dr,
    output logic                       dr_idle,
    output logic                       rom_cs,
    output logic [obj_pkg::ROM_AW-1:0] rom_addr,
    input  logic                       rom_ok,
    input  logic [obj_pkg::ROM_DW-1:0] rom_data,
    output logic                       buf_we,
    output logic [8:0]                 buf_addr,
    output logic [obj_pkg::PIX_W-1:0]  buf_data
);

    obj_pkg::draw_state_t       state;
    obj_pkg::draw_req_t         req;
    logic [obj_pkg::ROM_DW-1:0] row;
    logic [3:0]                 cnt;    // buffer offset from hpos
    logic [3:0]                 col;    // pixel taken from the row
    logic [3:0]                 colour;

    assign dr_idle = state == obj_pkg::DRAW_IDLE;

    // hflip reads the row from the far end
    assign col    = req.attr[5] ? ~cnt : cnt;
    assign colour = row[{col, 2'b00} +: 4];

    assign buf_we   = state == obj_pkg::DRAW_PIXELS && colour != 4'hf;  // 15 is clear
    assign buf_addr = req.hpos + {5'd0, cnt};
    assign buf_data = {req.prio, req.attr[4:0], colour};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= obj_pkg::DRAW_IDLE;
            rom_cs   <= 1'b0;
            rom_addr <= '0;
            cnt      <= '0;
        end else begin
            case (state)
                obj_pkg::DRAW_IDLE: begin
                    if (dr_start) begin
                        state    <= obj_pkg::DRAW_FETCH;
                        rom_cs   <= 1'b1;
                        rom_addr <= {dr.bank, dr.code, dr.attr[11:8]};
                    end
                end
                obj_pkg::DRAW_FETCH: begin
                    if (rom_ok) begin
                        state  <= obj_pkg::DRAW_PIXELS;
                        rom_cs <= 1'b0;
                        cnt    <= '0;
                    end
                end
                obj_pkg::DRAW_PIXELS: begin
                    cnt <= cnt + 4'd1;
                    if (&cnt) begin
                        state <= obj_pkg::DRAW_IDLE;    // idle again after 16 writes
                    end
                end
                default: state <= obj_pkg::DRAW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == obj_pkg::DRAW_IDLE && dr_start) begin
            req <= dr;
        end
        if (state == obj_pkg::DRAW_FETCH && rom_ok) begin
            row <= rom_data;
        end
    end

    // scanner must wait for idle before each request
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        dr_start |-> state == obj_pkg::DRAW_IDLE);

endmodule

// ==== rtl/obj_scan.sv ====
/*
 * object table scanner
 * walks the table once per line and issues one draw request per visible tile
 */
`timescale 1ns/10ps

module obj_scan (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flip,
    input  logic [8:0]                   vrender1,
    input  logic [8:0]                   hdump,
    output logic                         line,
    input  logic [9:0]                   off_x,
    input  logic [9:0]                   off_y,
    output logic [obj_pkg::TABLE_AW-1:0] table_addr,
    input  obj_pkg::obj_entry_t          entry,
    output logic                         dr_start,
    input  logic                         dr_idle,
    output obj_pkg::draw_req_t           dr
);

    logic       start;
    logic       start_q;
    logic       scan_go;
    logic       first;      // cycle where the table address restarts
    logic       done;
    logic [8:0] vrenderf;
    logic [obj_pkg::TABLE_AW-1:0] addr_q;   // address behind entry
    logic       s2_valid;
    logic       s2_end;

    logic        st3_valid;
    logic [9:0]  st3_x;
    logic [9:0]  st3_y;
    logic [15:0] st3_code;
    logic [15:0] st3_attr;
    logic [2:0]  st3_prio;
    logic [1:0]  st3_bank;

    logic        st4_valid;
    logic [9:0]  st4_x;
    logic [9:0]  st4_y;
    logic [15:0] st4_code;
    logic [15:0] st4_attr;
    logic [2:0]  st4_prio;
    logic [1:0]  st4_bank;
    logic [3:0]  st4_vsub;

    logic        tm_cen;
    logic [15:0] tm_code;
    logic [15:0] tm_attr;
    logic [9:0]  tm_y;
    logic [4:0]  tm_col;
    logic        inzone;
    logic [15:0] code_mn;

    logic [4:0]  n;         // column held in the tile match
    logic [9:0]  col_off;   // x step of that column
    logic [9:0]  effx;
    logic        live4;
    logic        ready;
    logic        col_step;
    logic        issue;
    logic        stall;
    logic        last_drstart;

    assign start   = hdump == obj_pkg::SCAN_START;
    assign scan_go = start && !start_q;

    assign s2_valid = !done && !first;
    assign s2_end   = entry.y[15] || entry.attr[15:8] == 8'hff || &addr_q;

    assign effx     = st4_x + col_off;
    assign live4    = inzone && st4_valid;
    assign ready    = dr_idle && !dr_start && !last_drstart;
    assign col_step = live4 && (effx[9] || ready);  // off-screen columns just step
    assign issue    = live4 && !effx[9] && ready;
    assign stall    = live4 || dr_start || last_drstart;

    // the entry only moves on when stage 2 takes it
    always_comb begin
        if (first) begin
            table_addr = '0;
        end else if (stall || done) begin
            table_addr = addr_q;
        end else begin
            table_addr = addr_q + 1'b1;
        end
    end

    // stalled: next column of the stage 4 object, else the new object
    assign tm_cen  = !stall || col_step;
    assign tm_code = stall ? st4_code : st3_code;
    assign tm_attr = stall ? st4_attr : st3_attr;
    assign tm_y    = stall ? st4_y : st3_y;
    assign tm_col  = stall ? n + 5'd1 : 5'd0;

    obj_tile_match u_tile_match (
        .clk      (clk),
        .rst      (rst),
        .cen      (tm_cen),
        .obj_code (tm_code),
        .tile_m   (tm_attr[15:12]),
        .tile_n   (tm_attr[11:8]),
        .n        (tm_col),
        .vflip    (tm_attr[6]),
        .vrenderf (vrenderf),
        .obj_y    (tm_y),
        .vsub     (st4_vsub),
        .inzone   (inzone),
        .code_mn  (code_mn)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q      <= 1'b0;
            first        <= 1'b0;
            done         <= 1'b1;
            line         <= 1'b0;
            vrenderf     <= '0;
            addr_q       <= '0;
            st3_valid    <= 1'b0;
            st4_valid    <= 1'b0;
            n            <= '0;
            col_off      <= '0;
            dr_start     <= 1'b0;
            last_drstart <= 1'b0;
        end else begin
            start_q      <= start;
            first        <= scan_go;
            addr_q       <= table_addr;
            dr_start     <= issue;
            last_drstart <= dr_start;
            if (scan_go) begin
                line     <= ~line;
                vrenderf <= vrender1 ^ {1'b0, {8{flip}}};
                done     <= 1'b0;
            end else if (!stall && s2_valid && s2_end) begin
                done <= 1'b1;
            end
            if (!stall) begin
                st3_valid <= s2_valid && !s2_end;
                st4_valid <= st3_valid;
                n         <= '0;
                col_off   <= '0;
            end else if (col_step) begin
                n       <= n + 5'd1;
                col_off <= st4_attr[5] ? col_off - 10'd16 : col_off + 10'd16;  // hflip
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && s2_valid) begin
            st3_code <= entry.code;
            st3_attr <= entry.attr;
            st3_x    <= entry.x[9:0] + 10'h40 - (entry.attr[7] ? 10'd0 : off_x);
            st3_y    <= entry.y[9:0] + 10'h10 - (entry.attr[7] ? 10'd0 : off_y);
            st3_prio <= entry.x[15:13];
            st3_bank <= entry.y[14:13];
        end
        if (!stall) begin
            st4_code <= st3_code;
            st4_attr <= st3_attr;
            st4_x    <= st3_x;
            st4_y    <= st3_y;
            st4_prio <= st3_prio;
            st4_bank <= st3_bank;
        end
        if (issue) begin
            dr.code <= code_mn;
            dr.attr <= {4'd0, st4_vsub, st4_attr[7:0]};
            dr.hpos <= effx[8:0] - 9'd1;
            dr.prio <= st4_prio;
            dr.bank <= st4_bank;
        end
    end

    // one pulse per request, and the drawer has left idle right after it
    a_start_gap: assert property (@(posedge clk) disable iff (rst)
        dr_start |=> !dr_start && !dr_idle);

    // the walk of the previous line is over before the next one starts
    a_scan_done: assert property (@(posedge clk) disable iff (rst)
        scan_go |-> done && !st4_valid);

endmodule

// ==== rtl/obj_tile_match.sv ====
/*
 * tile match for one object at one tile column
 * vertical zone test, tile row and adjusted tile code
 */
`timescale 1ns/10ps

module obj_tile_match (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [15:0] obj_code,
    input  logic [3:0]  tile_m,
    input  logic [3:0]  tile_n,
    input  logic [4:0]  n,
    input  logic        vflip,
    input  logic [8:0]  vrenderf,
    input  logic [9:0]  obj_y,
    output logic [3:0]  vsub,
    output logic        inzone,
    output logic [15:0] code_mn
);

    logic [9:0] dy;         // line minus object top, mod 1024
    logic [3:0] row;
    logic       row_hit;
    logic       col_hit;

    assign dy      = {1'b0, vrenderf} - obj_y;
    assign row_hit = (dy[9:8] == 2'd0) && (dy[7:4] <= tile_m);
    assign col_hit = n <= {1'b0, tile_n};   // past the last column drops out
    assign row     = vflip ? tile_m - dy[7:4] : dy[7:4];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inzone <= 1'b0;
        end else if (cen) begin
            inzone <= row_hit && col_hit;
        end
    end

    // each nibble wraps on its own
    always_ff @(posedge clk) begin
        if (cen) begin
            vsub    <= dy[3:0] ^ {4{vflip}};
            code_mn <= {obj_code[15:8], obj_code[7:4] + row, obj_code[3:0] + n[3:0]};
        end
    end

endmodule

// ==== rtl/obj_frame_table.sv ====
/*
 * object frame table
 * host writes one word at a time, scanner reads whole entries
 */
`timescale 1ns/10ps

module obj_frame_table (
    input  logic                         clk,
    input  logic                         cpu_we,
    input  logic [obj_pkg::HOST_AW-1:0]  cpu_addr,
    input  logic [15:0]                  cpu_data,
    input  logic [obj_pkg::TABLE_AW-1:0] table_addr,
    output obj_pkg::obj_entry_t          entry
);

    localparam int DEPTH = 2 ** obj_pkg::TABLE_AW;

    // word 0 x, 1 y, 2 code, 3 attr
    logic [15:0] mem [4][DEPTH];

    for (genvar w = 0; w < 4; w++) begin : g_word
        always_ff @(posedge clk) begin
            if (cpu_we && cpu_addr[1:0] == 2'(w)) begin
                mem[w][cpu_addr[obj_pkg::HOST_AW-1:2]] <= cpu_data;
            end
        end
    end

    // all four words come back together one cycle later
    always_ff @(posedge clk) begin
        entry.x    <= mem[0][table_addr];
        entry.y    <= mem[1][table_addr];
        entry.code <= mem[2][table_addr];
        entry.attr <= mem[3][table_addr];
    end

endmodule

// ==== rtl/obj_pkg.sv ====
/*
 * object line engine shared definitions
 * table sizes, pixel format, draw request and drawer states
 */
package obj_pkg;

    // object table, 1024 entries of four 16-bit words
    localparam int TABLE_AW = 10;
    localparam int HOST_AW  = 12;   // entry index plus word select

    // hdump value that kicks off the table walk for the next line
    localparam logic [8:0] SCAN_START = 9'h1d0;

    // line buffer pixel, priority/palette/colour
    localparam int PIX_W = 12;
    localparam logic [PIX_W-1:0] PIX_EMPTY = '1;

    // graphics memory, bank/code/row in, one 16-pixel row out
    localparam int ROM_AW = 22;
    localparam int ROM_DW = 64;     // pixel 0 in the low nibble

    // one object table entry as read by the scanner
    typedef struct packed {
        logic [15:0] x;     // [15:13] priority
        logic [15:0] y;     // [15] end marker, [14:13] bank
        logic [15:0] code;
        logic [15:0] attr;  // rows, columns, abs, flips, palette
    } obj_entry_t;

    // one tile row for the line drawer
    typedef struct packed {
        logic [15:0] code;
        logic [15:0] attr;  // {4'd0, tile row, attr low byte}
        logic [8:0]  hpos;  // already one pixel to the left
        logic [2:0]  prio;
        logic [1:0]  bank;
    } draw_req_t;

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_FETCH,
        DRAW_PIXELS
    } draw_state_t;

endpackage
